// File: Makefile
# Verilator build and run for the L0 prefetch buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_prefetch_l0_buffer
FILELIST  ?= prefetch_l0_buffer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fetch_aligner.sv
////////////////////////////////////////
// instruction aligner of the L0 buffer
// holds the program counter, picks the
// halfwords out of the buffered lines and
// joins a 32-bit word across two lines
////////////////////////////////////////

`timescale 1ns/1ns

module fetch_aligner
  import prefetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       branch_i,
  input  addr_t      addr_i,
  input  logic       ready_i,

  input  line_slot_t cur_slot_i,
  input  line_slot_t next_slot_i,
  output logic       pop_o,

  output logic       valid_o,
  output instr_t     rdata_o,
  output addr_t      addr_o
);

  addr_t       pc_q;
  addr_t       pc_n;
  logic [2:0]  idx;
  half_t       lo_half;
  half_t       hi_half;
  logic        compressed;
  logic        crossword;
  logic        line_hit;
  logic        need_next;
  logic        take;

  // halfword i of a line
  function automatic half_t pick_half(line_t line, logic [2:0] i);
    half_t h;
    h = line[{i, 4'b0000} +: 16];
    return h;
  endfunction

  assign idx        = pc_q[3:1];
  assign lo_half    = pick_half(cur_slot_i.data, idx);
  assign compressed = (lo_half[1:0] != 2'b11);
  assign crossword  = (idx == 3'(LINE_HALVES - 1));
  assign line_hit   = cur_slot_i.valid &&
                      (cur_slot_i.base == (pc_q & ~addr_t'(LINE_BYTES - 1)));
  assign need_next  = crossword && !compressed;

  ////////////////////////////////////////
  // upper halfword selection
  ////////////////////////////////////////

  // a compressed word at the last index gets a zero upper half
  // so its data stays put while the next line arrives
  always_comb begin
    hi_half = '0;
    if (!crossword) begin
      hi_half = pick_half(cur_slot_i.data, idx + 3'd1);
    end else if (!compressed) begin
      hi_half = next_slot_i.data[15:0];
    end
  end

  assign valid_o = line_hit && (!need_next || next_slot_i.valid) && !branch_i;
  assign rdata_o = {hi_half, lo_half};
  assign addr_o  = pc_q;

  ////////////////////////////////////////
  // program counter
  ////////////////////////////////////////

  assign take  = valid_o && ready_i;
  assign pc_n  = pc_q + (compressed ? addr_t'(2) : addr_t'(4));
  // retire the current line once the pc walks past it
  assign pop_o = take && (pc_n[31:4] != pc_q[31:4]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (branch_i) begin
      pc_q <= addr_i;
    end else if (take) begin
      pc_q <= pc_n;
    end
  end

endmodule

// File: l0_line_fetch.sv
////////////////////////////////////////
// line fetcher of the L0 prefetch buffer
// runs the req/gnt/rvalid protocol towards
// instruction memory and keeps a current
// line plus one prefetched sequential line
////////////////////////////////////////

`timescale 1ns/1ns

module l0_line_fetch
  import prefetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // redirect from the core
  input  logic       flush_i,
  input  addr_t      flush_addr_i,

  // aligner side
  input  logic       pop_i,
  output line_slot_t cur_slot_o,
  output line_slot_t next_slot_o,

  // instruction memory side
  output logic       instr_req_o,
  output addr_t      instr_addr_o,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  line_t      instr_rdata_i,

  output logic       busy_o
);

  fetch_state_e state_q, state_n;
  addr_t        fetch_addr_q;
  addr_t        req_addr_q;
  addr_t        flush_line;
  logic         discard_q;
  logic         run_q;
  logic         slot_free;
  logic         line_arrived;
  line_slot_t   new_slot;
  line_slot_t   cur_q, cur_n;
  line_slot_t   nxt_q, nxt_n;

  assign flush_line   = flush_addr_i & ~addr_t'(LINE_BYTES - 1);
  assign slot_free    = ~cur_q.valid | ~nxt_q.valid;
  // a response counts only when no flush made it stale
  assign line_arrived = (state_q == FETCH_WAIT_RVALID) && instr_rvalid_i &&
                        !discard_q && !flush_i;
  assign new_slot     = '{valid: 1'b1, base: req_addr_q, data: instr_rdata_i};

  ////////////////////////////////////////
  // memory request machine
  ////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (flush_i || (run_q && slot_free)) begin
          state_n = FETCH_WAIT_GNT;
        end
      end
      FETCH_WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_n = FETCH_WAIT_RVALID;
        end
      end
      FETCH_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_n = FETCH_IDLE;
        end
      end
      default: state_n = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= FETCH_IDLE;
      fetch_addr_q <= '0;
      req_addr_q   <= '0;
      discard_q    <= 1'b0;
      run_q        <= 1'b0;
    end else begin
      state_q <= state_n;
      // nothing is fetched before the first redirect
      if (flush_i) begin
        run_q <= 1'b1;
      end
      // request address is frozen until the grant
      if (state_q == FETCH_IDLE && state_n == FETCH_WAIT_GNT) begin
        req_addr_q <= flush_i ? flush_line : fetch_addr_q;
      end
      if (flush_i) begin
        fetch_addr_q <= flush_line;
      end else if (state_q == FETCH_WAIT_GNT && instr_gnt_i && !discard_q) begin
        fetch_addr_q <= fetch_addr_q + addr_t'(LINE_BYTES);
      end
      // stale response tracking
      if (state_q == FETCH_WAIT_RVALID && instr_rvalid_i) begin
        discard_q <= 1'b0;
      end else if (flush_i && state_q != FETCH_IDLE) begin
        discard_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // two-slot line queue
  ////////////////////////////////////////

  always_comb begin
    cur_n = cur_q;
    nxt_n = nxt_q;
    if (pop_i) begin
      cur_n       = nxt_q;
      nxt_n.valid = 1'b0;
    end
    // returning line goes to the lowest empty slot
    if (line_arrived) begin
      if (!cur_n.valid) begin
        cur_n = new_slot;
      end else begin
        nxt_n = new_slot;
      end
    end
    if (flush_i) begin
      cur_n.valid = 1'b0;
      nxt_n.valid = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_q <= '0;
      nxt_q <= '0;
    end else begin
      cur_q <= cur_n;
      nxt_q <= nxt_n;
    end
  end

  assign cur_slot_o   = cur_q;
  assign next_slot_o  = nxt_q;
  assign instr_req_o  = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o = req_addr_q;
  assign busy_o       = (state_q != FETCH_IDLE);

endmodule

// File: prefetch_l0_buffer.f
prefetch_pkg.sv
l0_line_fetch.sv
fetch_aligner.sv
prefetch_l0_buffer.sv
tb_imem.sv
tb_prefetch_l0_buffer.sv

// File: prefetch_l0_buffer.sv
////////////////////////////////////////
// L0 instruction prefetch buffer top
// fetches 128-bit lines and serves the core
// one 16- or 32-bit instruction at a time
////////////////////////////////////////

`timescale 1ns/1ns

module prefetch_l0_buffer
  import prefetch_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  // core side
  input  logic   ready_i,
  input  logic   branch_i,
  input  addr_t  addr_i,
  output logic   valid_o,
  output instr_t rdata_o,
  output addr_t  addr_o,

  // instruction memory side
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  line_t  instr_rdata_i,

  output logic   busy_o
);

  line_slot_t cur_slot;
  line_slot_t next_slot;
  logic       pop;

  l0_line_fetch u_line_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (branch_i),
    .flush_addr_i   (addr_i),
    .pop_i          (pop),
    .cur_slot_o     (cur_slot),
    .next_slot_o    (next_slot),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (busy_o)
  );

  fetch_aligner u_aligner (
    .clk         (clk),
    .rst_n       (rst_n),
    .branch_i    (branch_i),
    .addr_i      (addr_i),
    .ready_i     (ready_i),
    .cur_slot_i  (cur_slot),
    .next_slot_i (next_slot),
    .pop_o       (pop),
    .valid_o     (valid_o),
    .rdata_o     (rdata_o),
    .addr_o      (addr_o)
  );

endmodule

// File: prefetch_pkg.sv
////////////////////////////////////////
// shared types for the L0 prefetch buffer
// line geometry, the buffered line slot and
// the fetcher's memory machine states
// import into any module that needs them
////////////////////////////////////////

package prefetch_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [15:0] half_t;

  // one memory line is 128 bits, halfword 0 sits in the low bits
  localparam int LINE_BYTES  = 16;
  localparam int LINE_HALVES = 8;

  typedef logic [LINE_BYTES*8-1:0] line_t;

  // a buffered line as seen by the aligner
  typedef struct packed {
    logic  valid;
    addr_t base;
    line_t data;
  } line_slot_t;

  // memory request machine
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID
  } fetch_state_e;

endpackage

// File: tb_imem.sv
////////////////////////////////////////
// instruction memory model for the testbench
// seeded halfword image, random grant and
// response delays, and protocol checks on
// the fetch side of the buffer
////////////////////////////////////////

`timescale 1ns/1ns

module tb_imem
  import prefetch_pkg::*;
#(
  parameter int SEED = 32'h227c_27c6
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_i,
  input  addr_t addr_i,
  input  logic  busy_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output line_t rdata_o,
  output int    errors_o
);

  // 4 KiB image, indexed by address bits 11:1
  half_t image [0:2047];
  int    seed = SEED;
  int    gnt_delay;
  int    rsp_delay;
  logic  rsp_pending;
  logic  waiting;
  addr_t rsp_addr;
  addr_t held_addr;

  function automatic int unsigned pick(int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic line_t build_line(addr_t base);
    line_t l;
    for (int i = 0; i < LINE_HALVES; i++) begin
      l[16*i +: 16] = image[{base[11:4], 3'(i)}];
    end
    return l;
  endfunction

  task automatic flag_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    errors_o++;
  endtask

  task automatic flag_error(string what);
    $display("error at %0t ns: %s", $time, what);
    errors_o++;
  endtask

  ////////////////////////////////////////
  // protocol checks, run before the drive
  ////////////////////////////////////////

  task automatic check_protocol();
    if (req_i && addr_i[3:0] != 4'd0) begin
      flag_value("instr_addr_o", addr_i, addr_i & 32'hffff_fff0);
    end
    if (waiting && !req_i) begin
      flag_error("instr_req_o dropped before its grant");
    end
    if (waiting && req_i && addr_i != held_addr) begin
      flag_value("instr_addr_o", addr_i, held_addr);
    end
    if (rsp_pending && req_i) begin
      flag_error("new request raised while a response is pending");
    end
    if ((req_i || rsp_pending) && !busy_i) begin
      flag_value("busy_o", 32'(busy_i), 32'd1);
    end
  endtask

  task automatic step();
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    if (rsp_pending) begin
      // response comes 1 to 3 cycles after the grant
      if (rsp_delay == 0) begin
        rvalid_o    = 1'b1;
        rdata_o     = build_line(rsp_addr);
        rsp_pending = 1'b0;
      end else begin
        rsp_delay--;
      end
    end else if (req_i) begin
      if (gnt_delay == 0) begin
        gnt_o       = 1'b1;
        rsp_pending = 1'b1;
        rsp_addr    = addr_i;
        rsp_delay   = int'(pick(3));
        gnt_delay   = int'(pick(3));
      end else begin
        gnt_delay--;
      end
    end
    waiting   = req_i && !gnt_o;
    held_addr = addr_i;
  endtask

  initial begin
    logic [31:0] r;
    half_t       h;
    errors_o    = 0;
    gnt_o       = 1'b0;
    rvalid_o    = 1'b0;
    rdata_o     = '0;
    rsp_pending = 1'b0;
    waiting     = 1'b0;
    rsp_addr    = '0;
    held_addr   = '0;
    gnt_delay   = 0;
    rsp_delay   = 0;
    for (int i = 0; i < 2048; i++) begin
      r = $random(seed);
      h = r[15:0];
      // about half the halfwords open a 32-bit instruction
      if (r[16]) begin
        h[1:0] = 2'b11;
      end else if (h[1:0] == 2'b11) begin
        h[1:0] = 2'b00;
      end
      image[i] = h;
    end
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        gnt_o       = 1'b0;
        rvalid_o    = 1'b0;
        rsp_pending = 1'b0;
        waiting     = 1'b0;
      end else begin
        check_protocol();
        step();
      end
    end
  end

endmodule

// File: tb_prefetch_l0_buffer.sv
////////////////////////////////////////
// testbench for the L0 prefetch buffer
// random core traffic with branches and
// back-pressure, checked against a pc model
// that reads the memory image directly
////////////////////////////////////////

`timescale 1ns/1ns

module tb_prefetch_l0_buffer
  import prefetch_pkg::*;
();

  localparam int SEED           = 32'h227c_27c6;
  localparam int N_INSTR        = 3000;
  localparam int TIMEOUT_CYCLES = N_INSTR * 20;

  logic   clk;
  logic   rst_n;
  logic   core_ready;
  logic   core_branch;
  addr_t  core_addr;
  logic   instr_valid;
  instr_t instr_rdata;
  addr_t  pc_out;
  logic   mem_req;
  addr_t  mem_addr;
  logic   mem_gnt;
  logic   mem_rvalid;
  line_t  mem_rdata;
  logic   busy;

  int     seed = SEED;
  int     errors;
  int     mem_errors;
  int     taken;
  int     cycles;
  int     branches;
  int     crosswords;
  int     since_branch;
  int     branch_gap;
  logic   timed_out;
  logic   after_branch;
  logic   stalled;
  addr_t  exp_pc;
  addr_t  held_addr;
  instr_t held_rdata;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  prefetch_l0_buffer u_prefetch_l0_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .ready_i        (core_ready),
    .branch_i       (core_branch),
    .addr_i         (core_addr),
    .valid_o        (instr_valid),
    .rdata_o        (instr_rdata),
    .addr_o         (pc_out),
    .instr_req_o    (mem_req),
    .instr_addr_o   (mem_addr),
    .instr_gnt_i    (mem_gnt),
    .instr_rvalid_i (mem_rvalid),
    .instr_rdata_i  (mem_rdata),
    .busy_o         (busy)
  );

  tb_imem #(
    .SEED (SEED)
  ) u_imem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (mem_req),
    .addr_i   (mem_addr),
    .busy_i   (busy),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata),
    .errors_o (mem_errors)
  );

  function automatic int unsigned roll(int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic half_t image_half(addr_t a);
    return u_imem.image[a[11:1]];
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  // nothing may move before the first branch
  task automatic expect_idle();
    if (instr_valid) report_mismatch("valid_o", 32'(instr_valid), 32'd0);
    if (mem_req) report_mismatch("instr_req_o", 32'(mem_req), 32'd0);
    if (busy) report_mismatch("busy_o", 32'(busy), 32'd0);
    if (pc_out != 32'd0) report_mismatch("addr_o", pc_out, 32'd0);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic drive_inputs();
    logic [7:0] line_no;
    logic [2:0] idx;
    core_ready = (roll(10) < 7);
    if (!core_branch && (since_branch >= branch_gap || roll(400) == 0)) begin
      line_no = 8'(roll(256));
      // half of the targets land near the end of a line
      idx = (roll(2) == 0) ? 3'd6 + 3'(roll(2)) : 3'(roll(8));
      core_addr    = {20'd0, line_no, idx, 1'b0};
      core_branch  = 1'b1;
      since_branch = 0;
      branch_gap   = 20 + int'(roll(41));
      branches++;
    end else begin
      core_branch = 1'b0;
      core_addr   = $random(seed);
    end
  endtask

  ////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////

  task automatic observe();
    half_t lo;
    half_t hi;
    logic  comp;
    if (core_branch) begin
      if (instr_valid) report_mismatch("valid_o", 32'(instr_valid), 32'd0);
      exp_pc       = core_addr;
      after_branch = 1'b1;
      stalled      = 1'b0;
    end else begin
      if (after_branch && pc_out != exp_pc) report_mismatch("addr_o", pc_out, exp_pc);
      after_branch = 1'b0;
      // back-pressure keeps the offered instruction
      if (stalled) begin
        if (!instr_valid) report_mismatch("valid_o", 32'(instr_valid), 32'd1);
        if (pc_out != held_addr) report_mismatch("addr_o", pc_out, held_addr);
        if (instr_rdata != held_rdata) report_mismatch("rdata_o", instr_rdata, held_rdata);
      end
      if (instr_valid) begin
        lo   = image_half(exp_pc);
        hi   = image_half(exp_pc + 32'd2);
        comp = (lo[1:0] != 2'b11);
        if (pc_out != exp_pc) report_mismatch("addr_o", pc_out, exp_pc);
        if (instr_rdata[15:0] != lo) begin
          report_mismatch("rdata_o[15:0]", 32'(instr_rdata[15:0]), 32'(lo));
        end
        if (!comp && instr_rdata[31:16] != hi) begin
          report_mismatch("rdata_o[31:16]", 32'(instr_rdata[31:16]), 32'(hi));
        end
        if (core_ready) begin
          if (!comp && exp_pc[3:1] == 3'd7) crosswords++;
          exp_pc = exp_pc + (comp ? 32'd2 : 32'd4);
          taken++;
          since_branch++;
        end
      end
      stalled    = instr_valid && !core_ready;
      held_addr  = pc_out;
      held_rdata = instr_rdata;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    core_ready   = 1'b0;
    core_branch  = 1'b0;
    core_addr    = '0;
    errors       = 0;
    taken        = 0;
    cycles       = 0;
    branches     = 0;
    crosswords   = 0;
    since_branch = 0;
    branch_gap   = 0;
    timed_out    = 1'b0;
    after_branch = 1'b0;
    stalled      = 1'b0;
    exp_pc       = '0;
    held_addr    = '0;
    held_rdata   = '0;
    repeat (5) begin
      @(posedge clk);
      #10;
      expect_idle();
    end
    @(negedge clk);
    rst_n = 1'b1;
    // a few quiet cycles before the first branch
    repeat (8) begin
      @(negedge clk);
      core_ready = (roll(10) < 7);
      #10;
      expect_idle();
    end
    while (taken < N_INSTR && !timed_out) begin
      @(negedge clk);
      drive_inputs();
      #10;
      observe();
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("timeout after %0d cycles with %0d of %0d instructions taken",
                 cycles, taken, N_INSTR);
        timed_out = 1'b1;
      end
    end
    if (crosswords == 0) begin
      $display("error: no 32-bit instruction at halfword index 7 was taken");
      errors++;
    end
    $display("done: %0d taken, %0d crossword, %0d branches, %0d model errors, %0d memory errors",
             taken, crosswords, branches, errors, mem_errors);
    if (errors == 0 && mem_errors == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
